//--- bench/motion_golden.txt
# send: word reply | push: dir duration increment incinc reply | enc: count up
# move: steps dir move_done gap | expect: output value | halt: cycles | idle: cycles
expect enable 0
expect microsteps 2
expect motor_current 8c
expect step 0
expect move_done 0
expect buffer_ready 1
send fe00000000000000 0
send 0000000000000000 201
send 1000000000005005 0
expect microsteps 5
expect motor_current 50
send 1400000000000009 0
send 0a00000000000001 0
expect enable 1
enc a 1
enc 3 0
push 1 4 7fffffffffffff9b 0 7
move 5 1 1 a
push 0 3 2000000000000000 1000000000000000 7
move 2 0 0 14
send 0a00000000000000 0
expect enable 0
push 1 1 7fffffffffffff9b 0 7
push 1 1 7fffffffffffff9b 0 7
push 1 1 7fffffffffffff9b 0 7
push 1 1 7fffffffffffff9b 0 7
expect buffer_ready 0
push 1 1 7fffffffffffff9b 0 7
expect buffer_ready 0
send 0a00000000000001 0
move 2 1 1 a
move 2 1 0 a
move 2 1 1 a
move 2 1 0 a
idle 100
push 0 1000 7fffffffffffff9b 0 7
push 0 1000 7fffffffffffff9b 0 7
halt 2
expect buffer_ready 1
expect step 0
expect dir 0
idle 200
expect move_done 0
expect encoder_fault 0

//--- motion.f
common/motion_pkg.sv
hdl/spi_word.sv
hdl/command_regs.sv
hdl/quad_enc.sv
move/move_buffer.sv
move/step_dda.sv
hdl/motion_top.sv
bench/motion_properties.sv
bench/motion_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f motion.f \
    --top-module motion_tb -o motion_sim &&
  ./obj_dir/motion_sim | grep "TEST OK" &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }

//--- bench/motion_tb.sv
module motion_tb;
  import motion_pkg::*;

  localparam int wait_limit = 60000;  // Cycles allowed per wait loop

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic cipo;
  logic enc_a;
  logic enc_b;
  logic halt_n;
  logic step;
  logic dir;
  logic enable;
  logic [2:0] microsteps;
  logic [7:0] motor_current;
  logic buffer_ready;
  logic move_done;
  logic encoder_fault;

  // Running totals sampled on the rising edge
  int cycle = 0;
  int step_total = 0;
  int done_total = 0;
  int last_rise = 0;
  int step_gap = 0;
  logic step_prev = 1'b0;
  logic done_prev = 1'b0;
  int step_seen = 0;
  int done_seen = 0;
  int enc_phase = 0;

  motion_top motion_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle     <= cycle + 1;
    step_prev <= step;
    done_prev <= move_done;
    if (step === 1'b1) begin
      step_total <= step_total + 1;
      if (!step_prev) begin  // Rising edge of step
        step_gap  <= cycle - last_rise;
        last_rise <= cycle;
      end
    end
    if (resetn && move_done !== done_prev) done_total <= done_total + 1;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK);
  endtask

  // One 64-bit SPI transfer, MSB first, SCK at an eighth of CLK
  task automatic spi_transfer(input logic [63:0] word, input logic [63:0] exp_reply);
    logic [63:0] rx;
    cs = 1'b0;
    wait_cycles(6);
    for (int i = 63; i >= 0; i--) begin
      copi = word[i];
      sck  = 1'b0;
      wait_cycles(4);
      rx[i] = cipo;
      sck   = 1'b1;
      wait_cycles(4);
    end
    sck = 1'b0;
    wait_cycles(8);
    cs = 1'b1;
    wait_cycles(8);
    check_value("cipo reply", rx, exp_reply);
  endtask

  task automatic push_move(input logic d, input logic [63:0] duration,
                           input logic [63:0] increment, input logic [63:0] incinc,
                           input logic [63:0] snap);
    spi_transfer({cmd_coordinated_step, 55'd0, d}, 64'd0);
    spi_transfer(duration, 64'd0);
    spi_transfer(increment, 64'd0);
    spi_transfer(incinc, snap);  // Snapshot set by the increment word
  endtask

  task automatic drive_encoder(input int n, input logic up);
    logic [1:0] gray [4];
    gray[0] = 2'b00;
    gray[1] = 2'b10;
    gray[2] = 2'b11;
    gray[3] = 2'b01;
    repeat (n) begin
      enc_phase = up ? (enc_phase + 1) % 4 : (enc_phase + 3) % 4;
      {enc_a, enc_b} = gray[enc_phase];
      wait_cycles(4);
    end
  endtask

  task automatic finish_move(input int steps, input logic exp_dir, input logic exp_done,
                             input int gap);
    int t;
    t = 0;
    while (!(done_total > done_seen && step == 1'b0)) begin
      t = t + 1;
      if (t > wait_limit) stop_run("Timed out waiting for a move to finish");
      @(negedge CLK);
    end
    check_value("move_done toggles", done_total, done_seen + 1);
    done_seen = done_total;
    check_value("step count", step_total - step_seen, steps);
    step_seen = step_total;
    check_value("dir", dir, exp_dir);
    check_value("move_done", move_done, exp_done);
    if (gap != 0) check_value("step period", step_gap, gap);
  endtask

  task automatic pulse_halt(input int low_cycles);
    int t;
    int snap;
    t = 0;
    snap = step_total;
    while (step_total <= snap) begin  // Halt only once stepping is under way
      t = t + 1;
      if (t > wait_limit) stop_run("Timed out waiting for stepping before halt");
      @(negedge CLK);
    end
    halt_n = 1'b0;
    wait_cycles(low_cycles);
    halt_n = 1'b1;
    wait_cycles(4);
    step_seen = step_total;
  endtask

  task automatic stay_idle(input int n);
    wait_cycles(n);
    check_value("step count while idle", step_total, step_seen);
    check_value("move_done toggles while idle", done_total, done_seen);
  endtask

  task automatic expect_output(input logic [127:0] name, input logic [63:0] exp);
    logic [63:0] got;
    got = '0;
    case (name)
      "enable":        got = 64'(enable);
      "microsteps":    got = 64'(microsteps);
      "motor_current": got = 64'(motor_current);
      "step":          got = 64'(step);
      "dir":           got = 64'(dir);
      "move_done":     got = 64'(move_done);
      "buffer_ready":  got = 64'(buffer_ready);
      "encoder_fault": got = 64'(encoder_fault);
      default: stop_run($sformatf("Unknown output name %0s in the golden file", name));
    endcase
    check_value($sformatf("%0s", name), got, exp);
  endtask

  initial begin
    int fd;
    int r;
    string line;
    logic [127:0] op;
    logic [127:0] name;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    logic [63:0] e;
    resetn = 1'b0;
    sck    = 1'b0;
    cs     = 1'b1;
    copi   = 1'b0;
    enc_a  = 1'b0;
    enc_b  = 1'b0;
    halt_n = 1'b1;
    wait_cycles(4);
    resetn = 1'b1;
    wait_cycles(2);
    fd = $fopen("bench/motion_golden.txt", "r");
    if (fd == 0) stop_run("Could not open bench/motion_golden.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      r = $sscanf(line, "%s", op);
      if (op == "send") begin
        r = $sscanf(line, "%s %h %h", op, a, b);
        spi_transfer(a, b);
      end else if (op == "push") begin
        r = $sscanf(line, "%s %h %h %h %h %h", op, a, b, c, d, e);
        push_move(a[0], b, c, d, e);
      end else if (op == "enc") begin
        r = $sscanf(line, "%s %h %h", op, a, b);
        drive_encoder(int'(a), b[0]);
      end else if (op == "move") begin
        r = $sscanf(line, "%s %h %h %h %h", op, a, b, c, d);
        finish_move(int'(a), b[0], c[0], int'(d));
      end else if (op == "expect") begin
        r = $sscanf(line, "%s %s %h", op, name, a);
        expect_output(name, a);
      end else if (op == "halt") begin
        r = $sscanf(line, "%s %h", op, a);
        pulse_halt(int'(a));
      end else if (op == "idle") begin
        r = $sscanf(line, "%s %h", op, a);
        stay_idle(int'(a));
      end else begin
        stop_run($sformatf("Unknown operation %0s in the golden file", op));
      end
    end
    $fclose(fd);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- bench/motion_properties.sv
module motion_properties (
  input logic                            CLK,
  input logic                            resetn,
  input logic                            word_received,
  input logic                            move_push,
  input logic [motion_pkg::buf_ptr_w:0]  wr_ptr,
  input logic                            buffer_ready,
  input logic                            move_done,
  input logic                            running
);

  // Received word strobe is a single cycle
  word_pulse: assert property (@(posedge CLK) disable iff (!resetn)
    word_received |=> !word_received)
    else $error("word_received held high for more than one cycle");

  // A push is taken only while the buffer reports ready, and dropped otherwise
  push_accept: assert property (@(posedge CLK) disable iff (!resetn)
    move_push |=> ((wr_ptr != $past(wr_ptr)) == $past(buffer_ready)))
    else $error("move push accepted or dropped against the buffer_ready level");

  done_on_idle: assert property (@(posedge CLK) disable iff (!resetn)
    (move_done != $past(move_done)) |-> ($past(running) && !running))
    else $error("move_done toggled without the step engine returning to idle");

endmodule

bind motion_top motion_properties motion_properties_i (
  .CLK           (CLK),
  .resetn        (resetn),
  .word_received (word_received),
  .move_push     (move_push),
  .wr_ptr        (move_buffer_i.wr_ptr),
  .buffer_ready  (buffer_ready),
  .move_done     (move_done),
  .running       (step_dda_i.running)
);

//--- hdl/motion_top.sv
module motion_top (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  output logic       cipo,
  input  logic       enc_a,
  input  logic       enc_b,
  input  logic       halt_n,
  output logic       step,
  output logic       dir,
  output logic       enable,
  output logic [2:0] microsteps,
  output logic [7:0] motor_current,
  output logic       buffer_ready,
  output logic       move_done,
  output logic       encoder_fault
);
  import motion_pkg::*;

  logic word_received;
  spi_word_t word_data;
  logic [word_w-1:0] reply_word;
  logic signed [word_w-1:0] enc_count;
  logic move_push;
  logic move_pop;
  logic move_avail;
  move_t move_in;
  move_t move_head;
  logic [7:0] clock_divisor;

  spi_word spi_word_i (.CLK, .resetn, .sck, .cs, .copi, .cipo, .reply_word,
                       .word_received, .word_data);

  command_regs command_regs_i (.CLK, .resetn, .word_received, .word_data, .enc_count,
                               .reply_word, .move_push, .move_in, .enable,
                               .clock_divisor, .microsteps, .motor_current);

  quad_enc quad_enc_i (.CLK, .resetn, .enc_a, .enc_b, .count(enc_count),
                       .fault(encoder_fault));

  move_buffer move_buffer_i (.CLK, .resetn, .halt_n, .move_push, .move_in, .move_pop,
                             .move_head, .move_avail, .buffer_ready);

  step_dda step_dda_i (.CLK, .resetn, .halt_n, .enable, .clock_divisor, .move_avail,
                       .move_head, .move_pop, .step, .dir, .move_done);

endmodule

//--- move/step_dda.sv
module step_dda (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              halt_n,
  input  logic              enable,
  input  logic [7:0]        clock_divisor,
  input  logic              move_avail,
  input  motion_pkg::move_t move_head,
  output logic              move_pop,
  output logic              step,
  output logic              dir,
  output logic              move_done
);
  import motion_pkg::*;

  logic running;
  logic tick;
  logic [7:0] tick_cnt;
  logic [word_w-1:0] ticks_left;
  logic signed [word_w-1:0] incr;
  logic signed [word_w-1:0] incinc;
  logic signed [word_w-1:0] accum;
  logic signed [word_w-1:0] accum_next;

  assign move_pop = !running && move_avail && enable && halt_n;  // Load from idle
  assign tick     = running && halt_n && (tick_cnt == 8'd0);
  assign step     = (accum > 0);

  // Step rollback and tick add can land in the same cycle
  always_comb begin
    accum_next = accum;
    if (step) accum_next = accum_next - step_threshold;
    if (tick) accum_next = accum_next + incr;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      running   <= 1'b0;
      tick_cnt  <= '0;
      accum     <= '0;
      dir       <= 1'b0;
      move_done <= 1'b0;
    end else begin
      accum <= accum_next;  // Kept across moves and halt
      if (!halt_n) begin
        running <= 1'b0;
      end else if (move_pop) begin
        running  <= 1'b1;
        tick_cnt <= clock_divisor;
        dir      <= move_head.dir;
      end else if (tick) begin
        tick_cnt <= clock_divisor;
        if (ticks_left == '0) begin
          running   <= 1'b0;
          move_done <= ~move_done;
        end
      end else if (running) begin
        tick_cnt <= tick_cnt - 8'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (move_pop) begin
      ticks_left <= move_head.duration;
      incr       <= move_head.increment;
      incinc     <= move_head.incinc;
    end else if (tick) begin
      ticks_left <= ticks_left - 1'b1;
      incr       <= incr + incinc;  // Acceleration term
    end
  end

endmodule

//--- move/move_buffer.sv
module move_buffer (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              halt_n,
  input  logic              move_push,
  input  motion_pkg::move_t move_in,
  input  logic              move_pop,
  output motion_pkg::move_t move_head,
  output logic              move_avail,
  output logic              buffer_ready
);
  import motion_pkg::*;

  move_t ring [buf_depth];
  logic [buf_ptr_w:0] wr_ptr;  // Extra MSB is the wrap bit
  logic [buf_ptr_w:0] rd_ptr;
  logic full;
  logic empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[buf_ptr_w] != rd_ptr[buf_ptr_w]) &&
                 (wr_ptr[buf_ptr_w-1:0] == rd_ptr[buf_ptr_w-1:0]);

  assign move_head    = ring[rd_ptr[buf_ptr_w-1:0]];
  assign move_avail   = !empty;
  assign buffer_ready = !full;

  always_ff @(posedge CLK) begin
    if (move_push && !full) ring[wr_ptr[buf_ptr_w-1:0]] <= move_in;
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (move_push && !full) wr_ptr <= wr_ptr + 1'b1;  // Full drops the push
      if (!halt_n) rd_ptr <= wr_ptr;  // Flush
      else if (move_pop && !empty) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- hdl/quad_enc.sv
module quad_enc (
  input  logic                                CLK,
  input  logic                                resetn,
  input  logic                                enc_a,
  input  logic                                enc_b,
  output logic signed [motion_pkg::word_w-1:0] count,
  output logic                                fault
);

  // Two synchronizer stages plus one history stage
  logic [2:0] a_sync;
  logic [2:0] b_sync;
  logic a_chg;
  logic b_chg;
  logic up;

  assign a_chg = a_sync[2] ^ a_sync[1];
  assign b_chg = b_sync[2] ^ b_sync[1];
  assign up    = ~(a_sync[2] ^ b_sync[1]);  // A leading B

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync <= '0;
      b_sync <= '0;
      count  <= '0;
      fault  <= 1'b0;
    end else begin
      a_sync <= {a_sync[1:0], enc_a};
      b_sync <= {b_sync[1:0], enc_b};
      if (a_chg && b_chg) begin
        fault <= 1'b1;  // Missed a state, sticky
      end else if (a_chg || b_chg) begin
        if (up) count <= count + 1'b1;
        else count <= count - 1'b1;
      end
    end
  end

endmodule

//--- hdl/command_regs.sv
module command_regs (
  input  logic                                CLK,
  input  logic                                resetn,
  input  logic                                word_received,
  input  motion_pkg::spi_word_t               word_data,
  input  logic signed [motion_pkg::word_w-1:0] enc_count,
  output logic [motion_pkg::word_w-1:0]        reply_word,
  output logic                                move_push,
  output motion_pkg::move_t                   move_in,
  output logic                                enable,
  output logic [7:0]                          clock_divisor,
  output logic [2:0]                          microsteps,
  output logic [7:0]                          motor_current
);
  import motion_pkg::*;

  logic [7:0] header_q;   // Header of the message in progress
  logic [1:0] word_cnt;
  logic       awaiting;
  logic signed [word_w-1:0] enc_snap;

  assign awaiting = (header_q == cmd_coordinated_step) || (header_q == cmd_api_version);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      header_q      <= '0;
      word_cnt      <= '0;
      enable        <= 1'b0;
      clock_divisor <= reset_clock_divisor;
      microsteps    <= reset_microsteps;
      motor_current <= reset_motor_current;
      reply_word    <= '0;
      move_push     <= 1'b0;
    end else begin
      move_push <= 1'b0;
      if (word_received) begin
        reply_word <= '0;
        if (!awaiting) begin
          header_q <= word_data.hdr.cmd;
          word_cnt <= 2'd1;
          case (word_data.hdr.cmd)
            cmd_motor_enable: enable <= word_data.hdr.cfg_low[0];
            cmd_clk_divisor:  clock_divisor <= word_data.hdr.cfg_low;
            cmd_motorconfig: begin
              motor_current <= word_data.hdr.cfg_current;
              microsteps    <= word_data.hdr.cfg_low[2:0];
            end
            cmd_api_version:
              reply_word <= {{(word_w-24){1'b0}}, version_major, version_minor, version_patch};
            default: ;
          endcase
        end else begin
          word_cnt <= word_cnt + 2'd1;
          if (header_q == cmd_api_version) begin
            header_q <= '0;  // Trailing word just closes the message
          end else begin
            case (word_cnt)
              2'd2: reply_word <= enc_snap;
              2'd3: begin
                move_push <= 1'b1;
                header_q  <= '0;
              end
              default: ;
            endcase
          end
        end
      end
    end
  end

  // Move record fields, filled word by word
  always_ff @(posedge CLK) begin
    if (word_received) begin
      if (!awaiting) begin
        if (word_data.hdr.cmd == cmd_coordinated_step) begin
          move_in.dir <= word_data.hdr.cfg_low[0];
          enc_snap    <= enc_count;
        end
      end else if (header_q == cmd_coordinated_step) begin
        case (word_cnt)
          2'd1: move_in.duration  <= word_data.raw;
          2'd2: move_in.increment <= word_data.raw;
          2'd3: move_in.incinc    <= word_data.raw;
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hdl/spi_word.sv
module spi_word (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         sck,
  input  logic                         cs,
  input  logic                         copi,
  output logic                         cipo,
  input  logic [motion_pkg::word_w-1:0] reply_word,
  output logic                         word_received,
  output motion_pkg::spi_word_t        word_data
);
  import motion_pkg::*;

  logic [1:0] sck_sync;
  logic       sck_prev;
  logic [1:0] cs_sync;
  logic       cs_prev;
  logic [1:0] copi_sync;
  logic [$clog2(word_w)-1:0] bit_cnt;
  logic [word_w-1:0] shift_in;
  logic [word_w-1:0] reply_sr;
  logic sck_rise;
  logic sck_fall;
  logic cs_fall;

  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign cs_fall  = ~cs_sync[1] & cs_prev;
  assign cipo     = reply_sr[word_w-1];  // MSB first

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= 2'b00;
      sck_prev  <= 1'b0;
      cs_sync   <= 2'b11;  // Deselected
      cs_prev   <= 1'b1;
      copi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      sck_prev  <= sck_sync[1];
      cs_sync   <= {cs_sync[0], cs};
      cs_prev   <= cs_sync[1];
      copi_sync <= {copi_sync[0], copi};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt       <= '0;
      word_received <= 1'b0;
    end else begin
      word_received <= 1'b0;
      if (cs_sync[1]) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;  // Wraps to 0 after the last bit
        if (&bit_cnt) word_received <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      shift_in <= {shift_in[word_w-2:0], copi_sync[1]};
      if (&bit_cnt) word_data.raw <= {shift_in[word_w-2:0], copi_sync[1]};
    end
  end

  // Falling edge after a full word loads the next reply instead of shifting
  always_ff @(posedge CLK) begin
    if (cs_fall) begin
      reply_sr <= reply_word;
    end else if (sck_fall && !cs_sync[1]) begin
      if (bit_cnt == '0) reply_sr <= reply_word;
      else reply_sr <= {reply_sr[word_w-2:0], 1'b0};
    end
  end

endmodule

//--- common/motion_pkg.sv
package motion_pkg;

  localparam int word_w    = 64;
  localparam int buf_depth = 4;
  localparam int buf_ptr_w = 2;

  // Command header codes, top byte of the first word
  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_motor_enable     = 8'h0a;
  localparam logic [7:0] cmd_motorconfig      = 8'h10;
  localparam logic [7:0] cmd_clk_divisor      = 8'h14;
  localparam logic [7:0] cmd_api_version      = 8'hfe;

  localparam logic [7:0] version_major = 8'd0;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd1;

  // Just under 2^63 so one step eats almost a full accumulator
  localparam logic signed [word_w-1:0] step_threshold = 64'h7fff_ffff_ffff_ff9b;

  localparam logic [7:0] reset_clock_divisor = 8'd40;
  localparam logic [2:0] reset_microsteps    = 3'd2;
  localparam logic [7:0] reset_motor_current = 8'd140;

  typedef struct packed {
    logic [7:0]  cmd;
    logic [39:0] spare;
    logic [7:0]  cfg_current;
    logic [7:0]  cfg_low;      // Enable, dir, microsteps or divisor
  } spi_header_t;

  typedef union packed {
    spi_header_t       hdr;
    logic [word_w-1:0] raw;
  } spi_word_t;

  typedef struct packed {
    logic                     dir;
    logic [word_w-1:0]        duration;
    logic signed [word_w-1:0] increment;
    logic signed [word_w-1:0] incinc;
  } move_t;

endpackage
